// File: build.f
rtl/dpcm_pkg.sv
rtl/dpcm_regs.sv
rtl/dpcm_rate_timer.sv
rtl/dpcm_fetch_ctrl.sv
rtl/dpcm_output_unit.sv
rtl/dpcm_channel.sv
verification/dpcm_tb.sv

// File: rtl/dpcm_channel.sv
// DPCM channel top level; connects registers, rate timer, fetch control and output unit
`timescale 1ns/100ps

module dpcm_channel (
	input  logic                   aclk,
	input  logic                   rst_n,
	input  dpcm_pkg::reg_write_t   cpu_wr,
	input  logic                   sample_valid,
	input  logic [7:0]             sample_data,
	output logic                   sample_req,
	output dpcm_pkg::sample_addr_t sample_addr,
	output dpcm_pkg::status_t      status,
	output dpcm_pkg::level_t       dmc_out
);

	dpcm_pkg::dpcm_config_t  cfg;
	dpcm_pkg::level_load_t   lvl_load;
	dpcm_pkg::enable_write_t ena_wr;
	logic                    tick;         // One per output step
	logic                    buffer_full;

	dpcm_regs i_regs (
		.aclk     (aclk),
		.rst_n    (rst_n),
		.cpu_wr   (cpu_wr),
		.cfg      (cfg),
		.lvl_load (lvl_load),
		.ena_wr   (ena_wr)
	);

	dpcm_rate_timer i_rate_timer (
		.aclk  (aclk),
		.rst_n (rst_n),
		.cfg   (cfg),
		.tick  (tick)
	);

	dpcm_fetch_ctrl i_fetch_ctrl (
		.aclk         (aclk),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.ena_wr       (ena_wr),
		.buffer_full  (buffer_full),
		.sample_valid (sample_valid),
		.sample_req   (sample_req),
		.sample_addr  (sample_addr),
		.status       (status)
	);

	dpcm_output_unit i_output_unit (
		.aclk         (aclk),
		.rst_n        (rst_n),
		.tick         (tick),
		.lvl_load     (lvl_load),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.buffer_full  (buffer_full),
		.dmc_out      (dmc_out)
	);

endmodule

// File: rtl/dpcm_fetch_ctrl.sv
// Sample fetch control; address and byte counters, memory request, loop and interrupt
`timescale 1ns/100ps

module dpcm_fetch_ctrl (
	input  logic                    aclk,
	input  logic                    rst_n,
	input  dpcm_pkg::dpcm_config_t  cfg,
	input  dpcm_pkg::enable_write_t ena_wr,
	input  logic                    buffer_full,
	input  logic                    sample_valid,
	output logic                    sample_req,
	output dpcm_pkg::sample_addr_t  sample_addr,
	output dpcm_pkg::status_t       status
);

	dpcm_pkg::sample_addr_t start_addr;
	dpcm_pkg::byte_count_t  start_count;
	dpcm_pkg::sample_addr_t addr_cnt;
	dpcm_pkg::byte_count_t  remain;
	logic                   req_pend;
	logic                   irq_flag;
	logic                   remain_zero;
	logic                   last_byte;
	logic                   restart;

	// Start at base + addr_reg*64, length len_reg*16+1
	assign start_addr  = dpcm_pkg::ADDR_BASE + {2'b00, cfg.addr_reg, 6'b000000};
	assign start_count = {cfg.len_reg, 4'b0000} + dpcm_pkg::byte_count_t'(1);

	assign remain_zero = (remain == '0);
	assign last_byte   = sample_valid && (remain == dpcm_pkg::byte_count_t'(1));

	// Loop at end of sample, or enable while idle
	assign restart = (last_byte && cfg.loop_en) ||
	                 (ena_wr.strobe && ena_wr.enable && remain_zero);

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			remain <= '0;
		end else if (ena_wr.strobe && !ena_wr.enable) begin
			remain <= '0;  // Disable stops playback
		end else if (restart) begin
			remain <= start_count;
		end else if (sample_valid && !remain_zero) begin
			remain <= remain - dpcm_pkg::byte_count_t'(1);
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			addr_cnt <= dpcm_pkg::ADDR_BASE;
		end else if (restart) begin
			addr_cnt <= start_addr;
		end else if (sample_valid) begin
			// Wraps into the upper half only
			addr_cnt <= (addr_cnt == 16'hFFFF) ? 16'h8000 : addr_cnt + 16'd1;
		end
	end

	// One outstanding request, raised while the buffer is empty
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			req_pend <= 1'b0;
		end else if (sample_valid) begin
			req_pend <= 1'b0;
		end else if (!req_pend && !buffer_full && !remain_zero) begin
			req_pend <= 1'b1;
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			irq_flag <= 1'b0;
		end else if (ena_wr.strobe || !cfg.irq_en) begin
			irq_flag <= 1'b0;  // Status write or IRQ disabled
		end else if (last_byte && !cfg.loop_en) begin
			irq_flag <= 1'b1;
		end
	end

	assign sample_req    = req_pend;
	assign sample_addr   = addr_cnt;
	assign status.irq    = irq_flag;
	assign status.active = !remain_zero;

endmodule

// File: rtl/dpcm_output_unit.sv
// Output path; sample buffer, shift register, bit counter and the delta level counter
`timescale 1ns/100ps

module dpcm_output_unit (
	input  logic                  aclk,
	input  logic                  rst_n,
	input  logic                  tick,
	input  dpcm_pkg::level_load_t lvl_load,
	input  logic                  sample_valid,
	input  logic [7:0]            sample_data,
	output logic                  buffer_full,
	output dpcm_pkg::level_t      dmc_out
);

	logic [7:0]       sample_buf;
	logic [7:0]       shift_reg;
	logic [2:0]       bit_cnt;
	logic             silent;
	logic             cycle_end;
	dpcm_pkg::level_t level;

	assign cycle_end = tick && (bit_cnt == 3'd7);  // Eighth bit of the cycle

	always_ff @(posedge aclk) begin
		if (sample_valid) begin
			sample_buf <= sample_data;
		end
		if (cycle_end && buffer_full) begin
			shift_reg <= sample_buf;  // Start next byte
		end else if (tick) begin
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			buffer_full <= 1'b0;
			bit_cnt     <= '0;
			silent      <= 1'b1;
		end else begin
			if (sample_valid) begin
				buffer_full <= 1'b1;
			end else if (cycle_end && buffer_full) begin
				buffer_full <= 1'b0;
			end
			if (tick) begin
				bit_cnt <= bit_cnt + 3'd1;
			end
			if (cycle_end) begin
				silent <= !buffer_full;  // Nothing to play
			end
		end
	end

	// Clamped +/-2 steps; a direct load always wins
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			level <= '0;
		end else if (lvl_load.load) begin
			level <= lvl_load.value;
		end else if (tick && !silent) begin
			if (shift_reg[0]) begin
				if (level <= 7'd125) begin
					level <= level + 7'd2;
				end
			end else if (level >= 7'd2) begin
				level <= level - 7'd2;
			end
		end
	end

	assign dmc_out = level;

endmodule

// File: rtl/dpcm_pkg.sv
// Shared types, widths and constants of the DPCM channel; referenced by scoped names
package dpcm_pkg;

	localparam int ADDR_W  = 16;  // Sample memory address
	localparam int LEVEL_W = 7;   // Output level counter
	localparam int COUNT_W = 12;  // Remaining bytes, up to 255*16+1

	typedef logic [ADDR_W-1:0]  sample_addr_t;
	typedef logic [LEVEL_W-1:0] level_t;
	typedef logic [COUNT_W-1:0] byte_count_t;
	typedef logic [7:0]         rate_period_t;

	// Register select, one code per host-visible register
	typedef enum logic [2:0] {
		reg_ctrl,    // Rate index, loop, IRQ enable
		reg_level,   // Direct output level
		reg_addr,    // Sample start address
		reg_len,     // Sample length
		reg_status   // Channel enable in shared status/control
	} dpcm_reg_e;

	typedef struct packed {
		logic       wr;    // One-cycle write strobe
		dpcm_reg_e  sel;
		logic [7:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [3:0] rate_idx;
		logic       loop_en;
		logic       irq_en;
		logic [7:0] addr_reg;
		logic [7:0] len_reg;
	} dpcm_config_t;

	typedef struct packed {
		logic   load;   // One-cycle pulse
		level_t value;
	} level_load_t;

	typedef struct packed {
		logic strobe;   // One-cycle pulse
		logic enable;   // Bit 4 of the written byte
	} enable_write_t;

	typedef struct packed {
		logic irq;
		logic active;
	} status_t;

	// Output step period in aclk cycles, indexed by rate_idx
	localparam rate_period_t RATE_TABLE [16] = '{
		8'd214, 8'd190, 8'd170, 8'd160, 8'd143, 8'd127, 8'd113, 8'd107,
		8'd95,  8'd80,  8'd71,  8'd64,  8'd53,  8'd42,  8'd36,  8'd27
	};

	localparam sample_addr_t ADDR_BASE = 16'hC000;  // Start of sample range

endpackage

// File: rtl/dpcm_rate_timer.sv
// Output step timer; a down counter reloaded from the rate table, one tick per period
`timescale 1ns/100ps

module dpcm_rate_timer (
	input  logic                   aclk,
	input  logic                   rst_n,
	input  dpcm_pkg::dpcm_config_t cfg,
	output logic                   tick
);

	dpcm_pkg::rate_period_t period_cnt;
	dpcm_pkg::rate_period_t period;

	// New rate only seen at the reload point
	assign period = dpcm_pkg::RATE_TABLE[cfg.rate_idx];

	assign tick = (period_cnt == 8'd1);  // Last cycle of the period

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			period_cnt <= dpcm_pkg::RATE_TABLE[0];
		end else if (tick) begin
			period_cnt <= period;  // Reload
		end else begin
			period_cnt <= period_cnt - 8'd1;
		end
	end

endmodule

// File: rtl/dpcm_regs.sv
// Channel register file; decodes host writes into configuration and one-cycle pulses
`timescale 1ns/100ps

module dpcm_regs (
	input  logic                    aclk,
	input  logic                    rst_n,
	input  dpcm_pkg::reg_write_t    cpu_wr,
	output dpcm_pkg::dpcm_config_t  cfg,
	output dpcm_pkg::level_load_t   lvl_load,
	output dpcm_pkg::enable_write_t ena_wr
);

	logic wr_ctrl;
	logic wr_level;
	logic wr_addr;
	logic wr_len;
	logic wr_status;

	// Select decode, qualified by the strobe
	always_comb begin
		wr_ctrl   = 1'b0;
		wr_level  = 1'b0;
		wr_addr   = 1'b0;
		wr_len    = 1'b0;
		wr_status = 1'b0;
		if (cpu_wr.wr) begin
			case (cpu_wr.sel)
				dpcm_pkg::reg_ctrl:   wr_ctrl   = 1'b1;
				dpcm_pkg::reg_level:  wr_level  = 1'b1;
				dpcm_pkg::reg_addr:   wr_addr   = 1'b1;
				dpcm_pkg::reg_len:    wr_len    = 1'b1;
				dpcm_pkg::reg_status: wr_status = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else begin
			if (wr_ctrl) begin
				cfg.rate_idx <= cpu_wr.data[3:0];
				cfg.loop_en  <= cpu_wr.data[6];
				cfg.irq_en   <= cpu_wr.data[7];
			end
			if (wr_addr) begin
				cfg.addr_reg <= cpu_wr.data;
			end
			if (wr_len) begin
				cfg.len_reg <= cpu_wr.data;
			end
		end
	end

	// Level and enable writes pass straight through as pulses
	assign lvl_load.load   = wr_level;
	assign lvl_load.value  = cpu_wr.data[6:0];
	assign ena_wr.strobe   = wr_status;
	assign ena_wr.enable   = cpu_wr.data[4];  // Channel enable bit

endmodule

// File: verification/dpcm_tb.sv
// Testbench for the DPCM channel; runs six directed tests with a random-delay memory model
`timescale 1ns/100ps

module dpcm_tb;

	localparam int BYTE_CYCLES    = 8 * int'(dpcm_pkg::RATE_TABLE[15]);  // One byte at rate 15
	localparam int TIMEOUT_CYCLES = 120 * BYTE_CYCLES;  // About 105 byte periods of tests

	logic                   aclk;
	logic                   rst_n;
	dpcm_pkg::reg_write_t   cpu_wr;
	logic                   sample_valid;
	logic [7:0]             sample_data;
	logic                   sample_req;
	dpcm_pkg::sample_addr_t sample_addr;
	dpcm_pkg::status_t      status;
	dpcm_pkg::level_t       dmc_out;

	string                  test_name;
	int                     error_count;
	int                     test_start_errors;
	int                     pass_count;
	int                     fail_count;
	int                     delta_errors;
	int                     delta_checks;
	int                     cycle_count;
	int                     resp_wait;
	logic [31:0]            rng_state = 32'd33702;
	logic [31:0]            resp_rnd;
	dpcm_pkg::sample_addr_t fetch_addr [$];  // Address of every answered fetch
	logic                   bit_queue [$];   // Fetched bits in playback order
	dpcm_pkg::level_t       model_level;
	dpcm_pkg::level_t       prev_out;
	dpcm_pkg::level_t       load_val;
	dpcm_pkg::level_t       exp_level;
	logic                   load_last;
	int                     step;

	dpcm_channel i_dpcm_channel (
		.aclk         (aclk),
		.rst_n        (rst_n),
		.cpu_wr       (cpu_wr),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.sample_req   (sample_req),
		.sample_addr  (sample_addr),
		.status       (status),
		.dmc_out      (dmc_out)
	);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return {16'h0000, rng_state[31:16]};
	endfunction

	function automatic dpcm_pkg::sample_addr_t start_address(input logic [7:0] addr_reg);
		return dpcm_pkg::ADDR_BASE + 16'(addr_reg) * 16'd64;
	endfunction

	// Address of fetch idx in a looping sample of count bytes
	function automatic dpcm_pkg::sample_addr_t fetch_addr_at(input dpcm_pkg::sample_addr_t start,
			input int count, input int idx);
		dpcm_pkg::sample_addr_t a;
		a = start;
		repeat (idx % count) begin
			a = (a == 16'hFFFF) ? 16'h8000 : a + 16'd1;
		end
		return a;
	endfunction

	// Walks the recorded bits until one moves the level; clamped bits give no change
	function automatic dpcm_pkg::level_t next_delta_level();
		logic b;
		while (bit_queue.size() > 0) begin
			b = bit_queue.pop_front();
			if (b && model_level <= 7'd125) begin
				model_level = model_level + 7'd2;
				return model_level;
			end
			if (!b && model_level >= 7'd2) begin
				model_level = model_level - 7'd2;
				return model_level;
			end
		end
		return model_level;
	endfunction

	task automatic write_reg(input dpcm_pkg::dpcm_reg_e sel, input logic [7:0] data);
		@(posedge aclk);
		cpu_wr.wr   <= 1'b1;
		cpu_wr.sel  <= sel;
		cpu_wr.data <= data;
		@(posedge aclk);
		cpu_wr.wr <= 1'b0;
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("error %s (%s): expected 0x%0h, actual 0x%0h", test_name, what,
				expected, actual);
			error_count++;
		end
	endtask

	task automatic check_true(input logic cond, input string message);
		assert (cond) else begin
			$display("failure in %s: %s", test_name, message);
			error_count++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name         = name;
		test_start_errors = error_count;
	endtask

	task automatic end_test();
		if (error_count == test_start_errors) begin
			pass_count++;
			$display("test %s: passed", test_name);
		end else begin
			fail_count++;
			$display("test %s: failed", test_name);
		end
	endtask

	// Counts answered fetches, optionally checking that the channel stays active
	task automatic wait_fetches(input int count, input logic expect_active);
		int seen;
		int drops;
		seen  = 0;
		drops = 0;
		while (seen < count) begin
			@(posedge aclk);
			if (sample_valid) seen++;
			if (expect_active && !status.active) drops++;
		end
		check_value("cycles with active low", 0, drops);
	endtask

	task automatic check_fetch_addrs(input int base, input dpcm_pkg::sample_addr_t start,
			input int count, input int total);
		check_value("fetch count", total, fetch_addr.size() - base);
		for (int i = 0; i < total && base + i < fetch_addr.size(); i++) begin
			check_value($sformatf("address of fetch %0d", i + 1),
				fetch_addr_at(start, count, i), fetch_addr[base + i]);
		end
	endtask

	// Memory model, answers each request after 1 to 6 cycles
	always @(posedge aclk) begin
		if (!rst_n) begin
			resp_wait = 0;
		end else if (sample_valid) begin
			sample_valid <= 1'b0;
		end else if (resp_wait > 0) begin
			resp_wait = resp_wait - 1;
			if (resp_wait == 0) begin
				resp_rnd = next_random();
				sample_data  <= resp_rnd[7:0];
				sample_valid <= 1'b1;
				fetch_addr.push_back(sample_addr);
				for (int k = 0; k < 8; k++) begin
					bit_queue.push_back(resp_rnd[k]);  // LSB plays first
				end
			end
		end else if (sample_req) begin
			resp_wait = 1 + int'(next_random() % 32'd6);
		end
	end

	// Delta output checker, compares only the order of level changes
	always @(posedge aclk) begin
		if (!rst_n) begin
			model_level = '0;
			prev_out    = '0;
			load_last   = 1'b0;
		end else begin
			if (load_last) begin
				model_level = load_val;
			end else if (dmc_out != prev_out) begin
				exp_level = next_delta_level();
				step      = int'(dmc_out) - int'(prev_out);
				delta_checks++;
				assert ((step == 2 || step == -2) && dmc_out == exp_level) else begin
					$display("error delta output: expected %0d, actual %0d", exp_level, dmc_out);
					delta_errors++;
				end
			end
			prev_out  = dmc_out;
			load_last = cpu_wr.wr && cpu_wr.sel == dpcm_pkg::reg_level;
			load_val  = cpu_wr.data[6:0];
		end
	end

	req_drops_after_valid: assert property (@(posedge aclk) disable iff (!rst_n)
		sample_valid |=> !sample_req) else begin
		$display("sample_req stayed high in the cycle after sample_valid");
		error_count++;
	end

	addr_stable_during_req: assert property (@(posedge aclk) disable iff (!rst_n)
		sample_req && !sample_valid |=> $stable(sample_addr)) else begin
		$display("sample_addr changed while a request was pending");
		error_count++;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge aclk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [31:0]      rnd;
		dpcm_pkg::level_t lvl_val;
		int               base;
		int               rises;
		logic             req_prev;

		error_count  = 0;
		pass_count   = 0;
		fail_count   = 0;
		delta_errors = 0;
		delta_checks = 0;
		rst_n        = 1'b0;
		cpu_wr       = '0;
		sample_valid = 1'b0;
		sample_data  = 8'h00;
		repeat (16) @(posedge aclk);
		rst_n <= 1'b1;
		@(posedge aclk);

		begin_test("direct level load");
		check_value("sample_req after reset", 0, sample_req);
		check_value("status after reset", 0, status);
		check_value("dmc_out after reset", 0, dmc_out);
		rnd     = next_random();
		lvl_val = rnd[6:0];
		write_reg(dpcm_pkg::reg_level, {1'b0, lvl_val});
		@(posedge aclk);
		check_value("dmc_out", lvl_val, dmc_out);
		end_test();

		begin_test("start address and byte count");
		write_reg(dpcm_pkg::reg_ctrl, 8'h0F);  // Rate 15, no loop, no IRQ
		write_reg(dpcm_pkg::reg_addr, 8'h21);
		write_reg(dpcm_pkg::reg_len, 8'h01);
		base = fetch_addr.size();
		write_reg(dpcm_pkg::reg_status, 8'h10);
		wait_fetches(17, 1'b1);
		@(posedge aclk);
		check_true(!status.active, "status.active still high after the last byte");
		check_value("first address", 16'hC840, fetch_addr[base]);
		repeat (BYTE_CYCLES) @(posedge aclk);
		check_fetch_addrs(base, start_address(8'h21), 17, 17);
		end_test();

		begin_test("delta output");
		repeat (2 * BYTE_CYCLES) @(posedge aclk);  // Last two bytes play out
		check_true(delta_checks > 0, "dmc_out never changed during playback");
		check_value("delta mismatches", 0, delta_errors);
		end_test();

		begin_test("interrupt");
		write_reg(dpcm_pkg::reg_ctrl, 8'h8F);
		write_reg(dpcm_pkg::reg_addr, 8'h10);
		write_reg(dpcm_pkg::reg_len, 8'h00);  // One byte
		write_reg(dpcm_pkg::reg_status, 8'h10);
		@(posedge aclk);
		check_value("irq while playing", 0, status.irq);
		wait_fetches(1, 1'b1);
		@(posedge aclk);
		check_value("irq after last byte", 1, status.irq);
		write_reg(dpcm_pkg::reg_status, 8'h00);
		@(posedge aclk);
		check_value("irq after status write", 0, status.irq);
		write_reg(dpcm_pkg::reg_status, 8'h10);
		wait_fetches(1, 1'b1);
		@(posedge aclk);
		check_value("irq after second sample", 1, status.irq);
		write_reg(dpcm_pkg::reg_ctrl, 8'h0F);
		repeat (2) @(posedge aclk);  // Clear follows the registered irq_en
		check_value("irq after irq_en cleared", 0, status.irq);
		end_test();

		begin_test("loop and wrap");
		write_reg(dpcm_pkg::reg_ctrl, 8'h4F);  // Loop, rate 15
		write_reg(dpcm_pkg::reg_addr, 8'hFF);
		write_reg(dpcm_pkg::reg_len, 8'h04);  // 65 bytes, crosses 0xFFFF
		base = fetch_addr.size();
		write_reg(dpcm_pkg::reg_status, 8'h10);
		wait_fetches(66, 1'b1);
		check_fetch_addrs(base, start_address(8'hFF), 65, 66);
		check_value("address after 0xFFFF", 16'h8000, fetch_addr[base + 64]);
		check_value("address after loop", 16'hFFC0, fetch_addr[base + 65]);
		check_true(status.active, "status.active low while looping");
		end_test();

		begin_test("disable");
		write_reg(dpcm_pkg::reg_status, 8'h00);
		@(posedge aclk);
		check_true(!status.active, "status.active still high after disable");
		rises    = 0;
		req_prev = sample_req;
		repeat (2 * BYTE_CYCLES) begin
			@(posedge aclk);
			if (sample_req && !req_prev) rises++;
			req_prev = sample_req;
		end
		check_value("sample_req rises after disable", 0, rises);
		end_test();

		$display("tests passed %0d, failed %0d, delta errors %0d", pass_count, fail_count,
			delta_errors);
		if (fail_count == 0 && error_count == 0 && delta_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
